/* rs_pkg.sv */
package rs_pkg;

    // ==============================
    // sizes
    // ==============================
    localparam int rs_entries    = 8;                  // reservation station depth
    localparam int rs_ways       = 3;                  // dispatch, issue and cdb width
    localparam int xlen          = 32;                 // program counter width
    localparam int pr_bits       = 6;                  // physical register tag width
    localparam int fu_units      = 8;                  // number of functional units
    localparam int rs_idx_bits   = $clog2(rs_entries);
    localparam int rs_tree_nodes = 2 * rs_entries - 1; // nodes of the oldest-first tree

    // ==============================
    // encodings
    // ==============================
    typedef enum logic [1:0] {alu, ls, mult, branch} fu_class_e;

    // the value of each unit equals its bit position in fu_state_packet
    typedef enum logic [2:0] {
        alu_1, alu_2, alu_3, ls_1, ls_2, mult_1, mult_2, branch_1
    } fu_unit_e;

    typedef enum logic [2:0] {add, sub, and_op, or_op, load, store, mul, beq} op_e;

    // ==============================
    // packets
    // ==============================
    typedef struct packed {
        logic                valid;
        fu_class_e           fu_class;
        op_e                 op;
        logic [xlen-1:0]     pc;
        logic [pr_bits-1:0]  dest_pr;
        logic [pr_bits-1:0]  src1_pr;
        logic                src1_ready;
        logic [pr_bits-1:0]  src2_pr;
        logic                src2_ready;
    } rs_in_packet;

    typedef struct packed {
        logic                valid;
        fu_unit_e            fu_unit;
        op_e                 op;
        logic [xlen-1:0]     pc;
        logic [pr_bits-1:0]  dest_pr;
        logic [pr_bits-1:0]  src1_pr;
        logic [pr_bits-1:0]  src2_pr;
    } issue_packet;

    typedef struct packed {
        logic                valid;
        logic [pr_bits-1:0]  pr;                  // completing physical register
    } cdb_tag_packet;

    typedef struct packed {
        cdb_tag_packet [rs_ways-1:0] tags;
    } cdb_packet;

    // msb first, so alu_1 lands on bit 0
    typedef struct packed {
        logic branch_1;
        logic mult_2;
        logic mult_1;
        logic ls_2;
        logic ls_1;
        logic alu_3;
        logic alu_2;
        logic alu_1;
    } fu_state_packet;

    // units that can serve a class, as a mask over fu_state_packet bits
    function automatic logic [fu_units-1:0] class_units(fu_class_e fu_class);
        case (fu_class)
            alu:     return 8'b0000_0111;
            ls:      return 8'b0001_1000;
            mult:    return 8'b0110_0000;
            branch:  return 8'b1000_0000;
            default: return 8'b0000_0000;
        endcase
    endfunction

endpackage

/* rs_alloc.sv */
module rs_alloc (
    input  rs_pkg::rs_in_packet [rs_pkg::rs_entries-1:0]       entries,
    input  logic [rs_pkg::rs_entries-1:0]                      issued,
    output logic [rs_pkg::rs_ways-1:0][rs_pkg::rs_entries-1:0] grant,
    output logic [rs_pkg::rs_ways-1:0]                         stall
);
    import rs_pkg::*;

    logic [rs_entries-1:0] free;   // empty now or emptied by this cycle's issue
    logic [rs_entries-1:0] avail;  // free entries not yet granted to a higher lane
    logic [rs_ways-1:0]    found;  // lane found an entry

    always_comb begin
        for (int i = 0; i < rs_entries; i++) begin
            free[i] = ~entries[i].valid | issued[i];
        end
    end

    // ==============================
    // chained lowest-index pickers
    // ==============================
    // lane 2 picks from the full free set, then lane 1, then lane 0
    always_comb begin
        avail = free;
        for (int k = rs_ways - 1; k >= 0; k--) begin
            grant[k] = avail & (~avail + 1'b1); // isolate the lowest set bit
            found[k] = |avail;
            avail    = avail & ~grant[k];
        end
    end

    assign stall = ~found;

endmodule

/* rs_issue_slot.sv */
module rs_issue_slot (
    input  rs_pkg::rs_in_packet [rs_pkg::rs_entries-1:0] entries,
    input  logic [rs_pkg::rs_entries-1:0]                taken_in,
    input  rs_pkg::fu_state_packet                       fu_free_in,
    output logic [rs_pkg::rs_entries-1:0]                taken_out,
    output rs_pkg::fu_state_packet                       fu_free_out,
    output rs_pkg::issue_packet                          pick
);
    import rs_pkg::*;

    logic [fu_units-1:0]    free_units;
    logic [rs_entries-1:0]  cand;
    logic                   node_vld [rs_tree_nodes];
    logic [xlen-1:0]        node_pc  [rs_tree_nodes];
    logic [rs_idx_bits-1:0] node_idx [rs_tree_nodes];
    logic                   sel_vld;
    logic [rs_idx_bits-1:0] sel_idx;
    rs_in_packet            sel;
    logic [fu_units-1:0]    unit_mask;
    logic [fu_units-1:0]    unit_onehot;
    fu_unit_e               unit;

    assign free_units = fu_free_in;

    // ready operands, not claimed by an earlier lane, and some unit of the class still free
    always_comb begin
        for (int i = 0; i < rs_entries; i++) begin
            cand[i] = entries[i].valid && entries[i].src1_ready && entries[i].src2_ready
                      && !taken_in[i]
                      && (|(class_units(entries[i].fu_class) & free_units));
        end
    end

    // ==============================
    // oldest-first comparison tree
    // ==============================
    // heap layout, leaves in entry order so the left child always holds the lower index
    always_comb begin
        for (int i = 0; i < rs_entries; i++) begin
            node_vld[rs_entries-1+i] = cand[i];
            node_pc[rs_entries-1+i]  = entries[i].pc;
            node_idx[rs_entries-1+i] = rs_idx_bits'(i);
        end
        for (int n = rs_entries - 2; n >= 0; n--) begin
            if (node_vld[2*n+1]
                && (!node_vld[2*n+2] || node_pc[2*n+1] <= node_pc[2*n+2])) begin
                node_vld[n] = 1'b1;
                node_pc[n]  = node_pc[2*n+1];  // equal pc goes left, to the lower index
                node_idx[n] = node_idx[2*n+1];
            end else begin
                node_vld[n] = node_vld[2*n+2];
                node_pc[n]  = node_pc[2*n+2];
                node_idx[n] = node_idx[2*n+2];
            end
        end
    end

    assign sel_vld = node_vld[0];
    assign sel_idx = node_idx[0];
    assign sel     = entries[sel_idx];

    // ==============================
    // unit assignment
    // ==============================
    always_comb begin
        unit_mask   = sel_vld ? (class_units(sel.fu_class) & free_units) : '0;
        unit_onehot = unit_mask & (~unit_mask + 1'b1); // lowest-numbered free unit
        unit        = alu_1;
        for (int u = 0; u < fu_units; u++) begin
            if (unit_onehot[u]) begin
                unit = fu_unit_e'(3'(u));
            end
        end
    end

    assign fu_free_out = fu_state_packet'(free_units & ~unit_onehot);

    always_comb begin
        taken_out = taken_in;
        if (sel_vld) begin
            taken_out[sel_idx] = 1'b1;
        end
    end

    always_comb begin
        pick.valid   = sel_vld;
        pick.fu_unit = unit;
        pick.op      = sel.op;
        pick.pc      = sel.pc;
        pick.dest_pr = sel.dest_pr;
        pick.src1_pr = sel.src1_pr;
        pick.src2_pr = sel.src2_pr;
    end

endmodule

/* rs_issue.sv */
module rs_issue (
    input  rs_pkg::rs_in_packet [rs_pkg::rs_entries-1:0] entries,
    input  rs_pkg::fu_state_packet                       fu_ready,
    output rs_pkg::issue_packet [rs_pkg::rs_ways-1:0]    issue,
    output logic [rs_pkg::rs_entries-1:0]                issued
);
    import rs_pkg::*;

    logic [rs_entries-1:0] taken_01;    // entries claimed by lane 0
    logic [rs_entries-1:0] taken_12;    // entries claimed by lanes 0 and 1
    fu_state_packet        fu_free_01;  // units left after lane 0
    fu_state_packet        fu_free_12;  // units left after lane 1

    // lane 0 picks first and sees every unit that reports ready
    rs_issue_slot u_slot_0 (
        .entries     (entries),
        .taken_in    ({rs_entries{1'b0}}),
        .fu_free_in  (fu_ready),
        .taken_out   (taken_01),
        .fu_free_out (fu_free_01),
        .pick        (issue[0])
    );

    rs_issue_slot u_slot_1 (
        .entries     (entries),
        .taken_in    (taken_01),
        .fu_free_in  (fu_free_01),
        .taken_out   (taken_12),
        .fu_free_out (fu_free_12),
        .pick        (issue[1])
    );

    // last lane, nothing further consumes the remaining units
    rs_issue_slot u_slot_2 (
        .entries     (entries),
        .taken_in    (taken_12),
        .fu_free_in  (fu_free_12),
        .taken_out   (issued),
        .fu_free_out (),
        .pick        (issue[2])
    );

endmodule

/* rs_entry_table.sv */
module rs_entry_table (
    input  logic                                               clock,
    input  logic                                               reset,
    input  rs_pkg::rs_in_packet [rs_pkg::rs_ways-1:0]          rs_in,
    input  logic [rs_pkg::rs_ways-1:0][rs_pkg::rs_entries-1:0] grant,
    input  logic [rs_pkg::rs_entries-1:0]                      issued,
    input  rs_pkg::cdb_packet                                  cdb,
    output rs_pkg::rs_in_packet [rs_pkg::rs_entries-1:0]       entries
);
    import rs_pkg::*;

    rs_in_packet [rs_entries-1:0] entries_next;
    logic [rs_entries-1:0]        src1_wake;
    logic [rs_entries-1:0]        src2_wake;

    // ==============================
    // wakeup from the cdb
    // ==============================
    always_comb begin
        for (int i = 0; i < rs_entries; i++) begin
            src1_wake[i] = 1'b0;
            src2_wake[i] = 1'b0;
            for (int t = 0; t < rs_ways; t++) begin
                if (cdb.tags[t].valid && cdb.tags[t].pr == entries[i].src1_pr) begin
                    src1_wake[i] = 1'b1;
                end
                if (cdb.tags[t].valid && cdb.tags[t].pr == entries[i].src2_pr) begin
                    src2_wake[i] = 1'b1;
                end
            end
        end
    end

    // ==============================
    // next state
    // ==============================
    always_comb begin
        for (int i = 0; i < rs_entries; i++) begin
            entries_next[i]            = entries[i];
            entries_next[i].src1_ready = entries[i].src1_ready | src1_wake[i];
            entries_next[i].src2_ready = entries[i].src2_ready | src2_wake[i];
            if (issued[i]) begin
                entries_next[i].valid = 1'b0;
            end
            // grants never overlap, lane 2 is applied last and so has priority
            for (int k = 0; k < rs_ways; k++) begin
                if (grant[k][i] && rs_in[k].valid) begin
                    entries_next[i] = rs_in[k];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entries <= '0;
        end else begin
            entries <= entries_next;
        end
    end

endmodule

/* rs_top.sv */
module rs_top (
    input  logic                                      clock,
    input  logic                                      reset,
    input  rs_pkg::rs_in_packet [rs_pkg::rs_ways-1:0] rs_in,
    input  rs_pkg::cdb_packet                         cdb,
    input  rs_pkg::fu_state_packet                    fu_ready,
    output logic [rs_pkg::rs_ways-1:0]                stall,
    output rs_pkg::issue_packet [rs_pkg::rs_ways-1:0] issue
);
    import rs_pkg::*;

    rs_in_packet [rs_entries-1:0]       entries;  // registered entry table
    logic [rs_ways-1:0][rs_entries-1:0] grant;    // one-hot entry per dispatch lane
    logic [rs_entries-1:0]              issued;   // entries leaving this cycle

    // ==============================
    // allocation
    // ==============================
    rs_alloc u_rs_alloc (
        .entries (entries),
        .issued  (issued),
        .grant   (grant),
        .stall   (stall)
    );

    // ==============================
    // issue selection
    // ==============================
    rs_issue u_rs_issue (
        .entries  (entries),
        .fu_ready (fu_ready),
        .issue    (issue),
        .issued   (issued)
    );

    // ==============================
    // storage
    // ==============================
    rs_entry_table u_rs_entry_table (
        .clock   (clock),
        .reset   (reset),
        .rs_in   (rs_in),
        .grant   (grant),
        .issued  (issued),
        .cdb     (cdb),
        .entries (entries)
    );

endmodule

/* tb_rs.sv */
module tb_rs;
    timeunit 1ns;
    timeprecision 100ps;

    import rs_pkg::*;

    localparam int period_ns    = 10;
    localparam int reset_cycles = 4;
    localparam int n_cycles     = 2000;
    localparam int idle_cycles  = 8;
    localparam int settle_ns    = period_ns / 2 - 1;  // sample 1 ns before the rising edge
    localparam int watchdog_ns  = (reset_cycles + n_cycles + 100) * period_ns;

    logic                         clock;
    logic                         reset;
    rs_in_packet [rs_ways-1:0]    rs_in;
    cdb_packet                    cdb;
    fu_state_packet               fu_ready;
    logic [rs_ways-1:0]           stall;
    issue_packet [rs_ways-1:0]    issue;

    // reference model state and expected outputs
    rs_in_packet                  model_e [rs_entries];
    issue_packet                  exp_issue [rs_ways];
    logic [rs_entries-1:0]        exp_issued;
    logic [rs_ways-1:0][rs_entries-1:0] exp_grant;
    logic [rs_ways-1:0]           exp_stall;
    logic [rs_ways-1:0]           hold;       // stalled lane keeps its instruction
    logic [31:0]                  rng;
    int                           errors;
    int                           checks;
    int                           stall_cycles;
    int                           issue_count;
    int                           reuse_count;
    int                           wake_count;

    rs_top u_rs_top (
        .clock    (clock),
        .reset    (reset),
        .rs_in    (rs_in),
        .cdb      (cdb),
        .fu_ready (fu_ready),
        .stall    (stall),
        .issue    (issue)
    );

    initial begin
        clock = 1'b0;
        forever #(period_ns / 2) clock = ~clock;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("sim failed");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // unit numbering follows fu_unit_e, alu 0..2, ls 3..4, mult 5..6, branch 7
    function automatic int lowest_free_unit(input fu_class_e cls, input logic [7:0] free);
        int lo;
        int hi;
        case (cls)
            alu: begin
                lo = 0;
                hi = 2;
            end
            ls: begin
                lo = 3;
                hi = 4;
            end
            mult: begin
                lo = 5;
                hi = 6;
            end
            default: begin
                lo = 7;
                hi = 7;
            end
        endcase
        for (int u = lo; u <= hi; u++) begin
            if (free[u]) begin
                return u;
            end
        end
        return -1;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        errors++;
        $display("[ERROR] %s expected %h actual %h", name, expected, actual);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("error: %s", what);
    endtask

    // ==============================
    // stimulus
    // ==============================
    task automatic drive_inputs(input int c);
        logic idle;
        logic fill;
        idle = (c < idle_cycles);
        fill = !idle && (c % 100 < 25);  // all units busy, station fills up
        for (int k = 0; k < rs_ways; k++) begin
            if (!hold[k]) begin
                rng = xorshift(rng);
                rs_in[k].valid      = !idle && (fill || rng[31]);
                rs_in[k].fu_class   = fu_class_e'(rng[1:0]);
                rs_in[k].op         = op_e'(rng[4:2]);
                rs_in[k].pc         = 32'h1000 + {25'd0, rng[9:5], 2'b00};
                rs_in[k].dest_pr    = rng[15:10];
                rs_in[k].src1_pr    = {2'b00, rng[19:16]};
                rs_in[k].src1_ready = rng[20] | rng[21];
                rs_in[k].src2_pr    = {2'b00, rng[25:22]};
                rs_in[k].src2_ready = rng[26] | rng[27];
            end
        end
        rng = xorshift(rng);
        for (int t = 0; t < rs_ways; t++) begin
            cdb.tags[t].valid = !idle && !fill && rng[t];
            cdb.tags[t].pr    = {2'b00, rng[8 + 4 * t +: 4]};
        end
        if (idle) begin
            fu_ready = fu_state_packet'(8'hff);
        end else if (fill) begin
            fu_ready = fu_state_packet'(8'h00);
        end else if ((c / 100) % 2 == 1) begin
            fu_ready = fu_state_packet'(8'h01 << rng[30:28]);  // one unit, oldest-first matters
        end else begin
            fu_ready = fu_state_packet'(rng[23:16]);
        end
    endtask

    // ==============================
    // reference model
    // ==============================
    task automatic model_outputs();
        logic [7:0]            units_free;
        logic [rs_entries-1:0] taken;
        logic [rs_entries-1:0] free_mask;
        logic                  found;
        int                    best;
        int                    unit;
        units_free = fu_ready;
        taken      = '0;
        for (int k = 0; k < rs_ways; k++) begin
            best = -1;
            for (int i = 0; i < rs_entries; i++) begin
                if (model_e[i].valid && model_e[i].src1_ready && model_e[i].src2_ready
                    && !taken[i] && lowest_free_unit(model_e[i].fu_class, units_free) >= 0) begin
                    if (best < 0 || model_e[i].pc < model_e[best].pc) begin
                        best = i;  // strict compare keeps the lower index on a tie
                    end
                end
            end
            exp_issue[k] = '0;
            if (best >= 0) begin
                unit                 = lowest_free_unit(model_e[best].fu_class, units_free);
                exp_issue[k].valid   = 1'b1;
                exp_issue[k].fu_unit = fu_unit_e'(3'(unit));
                exp_issue[k].op      = model_e[best].op;
                exp_issue[k].pc      = model_e[best].pc;
                exp_issue[k].dest_pr = model_e[best].dest_pr;
                exp_issue[k].src1_pr = model_e[best].src1_pr;
                exp_issue[k].src2_pr = model_e[best].src2_pr;
                taken[best]          = 1'b1;
                units_free[unit]     = 1'b0;
            end
        end
        exp_issued = taken;
        for (int i = 0; i < rs_entries; i++) begin
            free_mask[i] = !model_e[i].valid || taken[i];
        end
        for (int k = rs_ways - 1; k >= 0; k--) begin
            exp_grant[k] = '0;
            found        = 1'b0;
            for (int i = 0; i < rs_entries; i++) begin
                if (free_mask[i] && !found) begin
                    exp_grant[k][i] = 1'b1;
                    free_mask[i]    = 1'b0;
                    found           = 1'b1;
                end
            end
            exp_stall[k] = !found;
        end
    endtask

    task automatic model_step();
        rs_in_packet e;
        for (int i = 0; i < rs_entries; i++) begin
            e = model_e[i];
            for (int t = 0; t < rs_ways; t++) begin
                if (cdb.tags[t].valid && cdb.tags[t].pr == e.src1_pr) begin
                    e.src1_ready = 1'b1;
                end
                if (cdb.tags[t].valid && cdb.tags[t].pr == e.src2_pr) begin
                    e.src2_ready = 1'b1;
                end
            end
            if (e.valid && (e.src1_ready != model_e[i].src1_ready
                            || e.src2_ready != model_e[i].src2_ready)) begin
                wake_count++;
            end
            if (exp_issued[i]) begin
                e.valid = 1'b0;
            end
            for (int k = 0; k < rs_ways; k++) begin
                if (exp_grant[k][i] && rs_in[k].valid) begin
                    e = rs_in[k];
                end
            end
            model_e[i] = e;
        end
    endtask

    task automatic check_outputs(input int c);
        logic [7:0] used;
        int         u;
        used = '0;
        checks++;
        if (stall !== exp_stall) begin
            report_mismatch("stall", 64'(exp_stall), 64'(stall));
        end
        for (int k = 0; k < rs_ways; k++) begin
            if (issue[k].valid !== exp_issue[k].valid) begin
                report_mismatch($sformatf("issue valid lane %0d", k),
                                64'(exp_issue[k].valid), 64'(issue[k].valid));
            end else if (exp_issue[k].valid && issue[k] !== exp_issue[k]) begin
                report_mismatch($sformatf("issue packet lane %0d", k),
                                64'(exp_issue[k]), 64'(issue[k]));
            end
            if (issue[k].valid === 1'b1) begin
                u = int'(issue[k].fu_unit);
                if (used[u]) begin
                    report_failure($sformatf("unit %0d issued twice in cycle %0d", u, c));
                end
                if (!fu_ready[u]) begin
                    report_failure($sformatf("unit %0d issued while busy in cycle %0d", u, c));
                end
                used[u] = 1'b1;
            end
        end
        if (c < idle_cycles && (|stall || issue[0].valid || issue[1].valid || issue[2].valid)) begin
            report_failure("stall or issue active right after reset with no dispatch");
        end
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial begin
        reset        = 1'b1;
        rs_in        = '0;
        cdb          = '0;
        fu_ready     = '0;
        hold         = '0;
        rng          = 32'h1e2b8e94;
        errors       = 0;
        checks       = 0;
        stall_cycles = 0;
        issue_count  = 0;
        reuse_count  = 0;
        wake_count   = 0;
        for (int i = 0; i < rs_entries; i++) begin
            model_e[i] = '0;
        end
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        for (int c = 0; c < n_cycles; c++) begin
            drive_inputs(c);
            model_outputs();
            #(settle_ns);
            check_outputs(c);
            model_step();
            if (|exp_stall) begin
                stall_cycles++;
            end
            for (int k = 0; k < rs_ways; k++) begin
                if (exp_issue[k].valid) begin
                    issue_count++;
                end
                if (rs_in[k].valid && |(exp_grant[k] & exp_issued)) begin
                    reuse_count++;  // dispatch lands in an entry that issues this cycle
                end
                hold[k] = rs_in[k].valid && exp_stall[k];
            end
            @(negedge clock);
        end
        if (stall_cycles == 0 || issue_count == 0 || reuse_count == 0 || wake_count == 0) begin
            report_failure("stimulus never reached stall, issue, entry reuse or wakeup");
        end
        $display("checks %0d errors %0d stall cycles %0d issued %0d reused %0d woken %0d",
                 checks, errors, stall_cycles, issue_count, reuse_count, wake_count);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* tb.f */
rs_pkg.sv
rs_alloc.sv
rs_issue_slot.sv
rs_issue.sv
rs_entry_table.sv
rs_top.sv
tb_rs.sv

/* run.sh */
#!/bin/sh
# build and run the reservation station testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f tb.f --top-module tb_rs --Mdir obj_dir -o tb_rs_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_rs_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
